// ==== include/wbuf_macros.svh ====
// Write buffer parameters
`ifndef WBUF_MACROS_SVH
`define WBUF_MACROS_SVH

// Number of posted writes the queue can hold
`define WBUF_DEPTH 8

// Reads wait for the queue to drain when set
`define WBUF_STALL_READ 1

// Word index width of the bus RAM, 256 words
`define RAM_ADDR_BITS 8

// Cycles from accepting a bus request to ready
`define RAM_LATENCY 2

`endif

// ==== hw/wbuf_pkg.sv ====
// Write buffer types
package wbuf_pkg;

	// Request from the host side, rw set for a write
	typedef struct packed {
		logic        rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} host_req_t;

	// Request toward the memory bus
	typedef struct packed {
		logic        rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// One posted write held in the queue
	typedef struct packed {
		logic [31:0] address;
		logic [31:0] data;
	} queue_entry_t;

endpackage

// ==== hw/write_queue.sv ====
// Posted write queue
`timescale 1ns/1ps

module write_queue #(
	parameter int DEPTH = 8
) (
	input  logic                  i_clock,
	input  logic                  i_rst,
	input  logic                  i_write,
	input  wbuf_pkg::queue_entry_t i_wdata,
	input  logic                  i_read,
	output wbuf_pkg::queue_entry_t o_rdata,
	output logic                  o_empty,
	output logic                  o_full
);
	import wbuf_pkg::*;

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	queue_entry_t mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic push;
	logic pop;

	// Pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign push = i_write && !o_full;
	assign pop = i_read && !o_empty;

	assign o_empty = (count == '0);
	assign o_full = (count == CNT_BITS'(DEPTH));

	// Head entry is always visible
	assign o_rdata = mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Push and pop together leave the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (push)
			mem[wr_ptr] <= i_wdata;
	end

endmodule

// ==== hw/write_buffer.sv ====
// Posted write buffer control
`timescale 1ns/1ps

module write_buffer #(
	parameter int DEPTH = 8,
	parameter bit STALL_READ = 1'b1
) (
	input  logic               i_clock,
	input  logic               i_rst,
	input  logic               i_request,
	input  wbuf_pkg::host_req_t i_req,
	output logic               o_ready,
	output logic [31:0]        o_rdata,
	output logic               o_empty,
	output logic               o_full,
	output logic               o_bus_request,
	output wbuf_pkg::bus_req_t  o_bus,
	input  logic               i_bus_ready,
	input  logic [31:0]        i_bus_rdata
);
	import wbuf_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_write_ack,
		st_bus_read,
		st_drain,
		st_terminate
	} state_t;

	state_t state;
	state_t next_state;

	logic wq_write;
	logic wq_read;
	queue_entry_t wq_wdata;
	queue_entry_t wq_rdata;
	logic wq_empty;
	logic wq_full;
	queue_entry_t drain_entry;
	logic stall_read;

	write_queue #(
		.DEPTH(DEPTH)
	) queue0 (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_write(wq_write),
		.i_wdata(wq_wdata),
		.i_read(wq_read),
		.o_rdata(wq_rdata),
		.o_empty(wq_empty),
		.o_full(wq_full)
	);

	assign o_empty = wq_empty;
	assign o_full = wq_full;
	assign o_rdata = i_bus_rdata;

	// A read may not overtake queued writes
	assign stall_read = STALL_READ && !wq_empty;

	always_ff @(posedge i_clock) begin
		if (i_rst)
			state <= st_idle;
		else
			state <= next_state;
	end

	// Entry being drained, taken from the head as it is popped
	always_ff @(posedge i_clock) begin
		if (wq_read)
			drain_entry <= wq_rdata;
	end

	always_comb begin
		next_state = state;
		wq_write = 1'b0;
		wq_read = 1'b0;
		wq_wdata.address = i_req.address;
		wq_wdata.data = i_req.wdata;
		o_ready = 1'b0;
		o_bus_request = 1'b0;
		o_bus = '0;

		case (state)
			st_idle: begin
				// Host requests win over draining
				if (i_request && i_req.rw && !wq_full) begin
					wq_write = 1'b1;
					next_state = st_write_ack;
				end else if (i_request && !i_req.rw && !stall_read) begin
					o_bus_request = 1'b1;
					o_bus.address = i_req.address;
					next_state = st_bus_read;
				end else if (!wq_empty) begin
					wq_read = 1'b1;
					next_state = st_drain;
				end
			end

			st_write_ack: begin
				o_ready = 1'b1;
				if (!i_request)
					next_state = st_idle;
			end

			st_bus_read: begin
				// Follows the host so the RAM sees the request drop
				o_bus_request = i_request;
				o_bus.address = i_req.address;
				o_ready = i_bus_ready;
				if (!i_request)
					next_state = st_idle;
			end

			st_drain: begin
				o_bus_request = 1'b1;
				o_bus.rw = 1'b1;
				o_bus.address = drain_entry.address;
				o_bus.wdata = drain_entry.data;
				if (i_bus_ready)
					next_state = st_terminate;
			end

			// One cycle with the bus request low before the next access
			st_terminate: begin
				next_state = st_idle;
			end

			default: begin
				next_state = st_idle;
			end
		endcase
	end

endmodule

// ==== hw/bus_ram.sv ====
// Fixed latency bus RAM
`timescale 1ns/1ps
`include "wbuf_macros.svh"

module bus_ram (
	input  logic              i_clock,
	input  logic              i_rst,
	input  logic              i_bus_request,
	input  wbuf_pkg::bus_req_t i_bus,
	output logic              o_bus_ready,
	output logic [31:0]       o_bus_rdata
);
	localparam int WORDS = 1 << `RAM_ADDR_BITS;
	localparam int LAT_BITS = $clog2(`RAM_LATENCY + 2);

	logic [31:0] mem [WORDS];
	logic [LAT_BITS-1:0] lat_count;
	logic wait_release;
	logic [`RAM_ADDR_BITS-1:0] word_index;
	logic access;

	assign word_index = i_bus.address[`RAM_ADDR_BITS+1:2];

	// Latency has run out on a fresh request
	assign access = i_bus_request && !wait_release
		&& (lat_count == LAT_BITS'(`RAM_LATENCY));

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			lat_count <= '0;
			wait_release <= 1'b0;
			o_bus_ready <= 1'b0;
		end else begin
			o_bus_ready <= access;
			if (wait_release) begin
				lat_count <= '0;
				// Served request must go low before another is taken
				if (!i_bus_request)
					wait_release <= 1'b0;
			end else if (access) begin
				lat_count <= '0;
				wait_release <= 1'b1;
			end else if (i_bus_request) begin
				lat_count <= lat_count + 1'b1;
			end else begin
				lat_count <= '0;
			end
		end
	end

	// Contents start at zero after reset
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			for (int i = 0; i < WORDS; i++)
				mem[i] <= '0;
		end else if (access && i_bus.rw) begin
			mem[word_index] <= i_bus.wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (access && !i_bus.rw)
			o_bus_rdata <= mem[word_index];
	end

endmodule

// ==== hw/buffered_memory.sv ====
// Buffered memory top level
`timescale 1ns/1ps
`include "wbuf_macros.svh"

module buffered_memory (
	input  logic               i_clock,
	input  logic               i_rst,
	input  logic               i_request,
	input  wbuf_pkg::host_req_t i_req,
	output logic               o_ready,
	output logic [31:0]        o_rdata,
	output logic               o_empty,
	output logic               o_full
);
	import wbuf_pkg::*;

	logic bus_request;
	bus_req_t bus;
	logic bus_ready;
	logic [31:0] bus_rdata;

	write_buffer #(
		.DEPTH(`WBUF_DEPTH),
		.STALL_READ(`WBUF_STALL_READ)
	) buffer0 (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_req(i_req),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_empty(o_empty),
		.o_full(o_full),
		.o_bus_request(bus_request),
		.o_bus(bus),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	// Slow memory behind the buffer
	bus_ram ram0 (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_bus_request(bus_request),
		.i_bus(bus),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata)
	);

endmodule

// ==== bench/clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 5
) (
	output logic o_clock,
	output logic o_rst
);
	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	// Reset covers whole cycles and drops on a falling edge
	initial begin
		o_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		@(negedge o_clock);
		o_rst = 1'b0;
	end

endmodule

// ==== bench/buffered_memory_props.sv ====
// Bus handshake properties
`timescale 1ns/1ps
`include "wbuf_macros.svh"

module buffered_memory_props (
	input logic               i_clock,
	input logic               i_rst,
	input logic               i_bus_request,
	input wbuf_pkg::bus_req_t i_bus,
	input logic               i_bus_ready
);
	// Request and fields hold until the RAM answers
	bus_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		i_bus_request && !i_bus_ready |=> i_bus_ready || (i_bus_request && $stable(i_bus)))
		else $error("bus request changed before ready");

	ready_single: assert property (@(posedge i_clock) disable iff (i_rst)
		i_bus_ready |=> !i_bus_ready)
		else $error("bus ready high for two cycles");

	// Terminate state leaves a low cycle after each drain write
	drain_gap: assert property (@(posedge i_clock) disable iff (i_rst)
		i_bus_request && i_bus.rw && i_bus_ready |=> !i_bus_request)
		else $error("bus request not released after a drain write");

	ready_latency: assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(i_bus_request) |-> ##(`RAM_LATENCY + 1) i_bus_ready)
		else $error("bus ready did not follow the fixed latency");

endmodule

bind write_buffer buffered_memory_props props0 (
	.i_clock(i_clock),
	.i_rst(i_rst),
	.i_bus_request(o_bus_request),
	.i_bus(o_bus),
	.i_bus_ready(i_bus_ready)
);

// ==== bench/buffered_memory_tb.sv ====
// Buffered memory testbench
`timescale 1ns/1ps
`include "wbuf_macros.svh"

module buffered_memory_tb;
	import wbuf_pkg::*;

	localparam int TIMEOUT = 400;

	logic i_clock;
	logic i_rst;
	logic i_request;
	host_req_t i_req;
	logic o_ready;
	logic [31:0] o_rdata;
	logic o_empty;
	logic o_full;

	// Expected memory contents start at zero like the RAM
	logic [31:0] model [1 << `RAM_ADDR_BITS];
	logic [31:0] addrs [10];
	logic [31:0] rnd;
	logic [31:0] addr;
	logic [31:0] got;
	logic full_low;
	integer seed;
	int cycles;
	int checks;
	int errors;
	int test_errors;
	int n;

	clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(5)) clock0 (.o_clock(i_clock), .o_rst(i_rst));

	buffered_memory dut0 (.*);

	function automatic logic [`RAM_ADDR_BITS-1:0] word_of(input logic [31:0] address);
		return address[`RAM_ADDR_BITS+1:2];
	endfunction

	task automatic check(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			$display("[FAIL] %0d ns: %s", $time, what);
			test_errors++;
		end
	endtask

	// Raise a request, wait for o_ready, drop the request on that edge
	task automatic access(input logic rw, input logic [31:0] address, input logic [31:0] wdata);
		int count;
		@(negedge i_clock);
		i_request = 1'b1;
		i_req.rw = rw;
		i_req.address = address;
		i_req.wdata = wdata;
		count = 0;
		full_low = 1'b0;
		do begin
			@(negedge i_clock);
			count++;
			if (!o_full)
				full_low = 1'b1;
		end while (!o_ready && count < TIMEOUT);
		assert (o_ready) else begin
			$display("Timeout at %0d ns, no o_ready for address %08h", $time, address);
			test_errors++;
		end
		got = o_rdata;
		cycles = count;
		i_request = 1'b0;
		// The model takes posted writes at the acknowledge
		if (rw)
			model[word_of(address)] = wdata;
	endtask

	task automatic read_check(input logic [31:0] address);
		access(1'b0, address, 32'h0);
		check(got === model[word_of(address)], $sformatf("read %08h returned %08h, expected %08h",
			address, got, model[word_of(address)]));
	endtask

	// The buffer drains while no requests are raised
	task automatic wait_idle();
		int count;
		count = 0;
		while (!(o_empty && !o_full) && count < TIMEOUT) begin
			@(negedge i_clock);
			count++;
		end
		assert (o_empty && !o_full) else begin
			$display("Timeout at %0d ns, the queue did not drain", $time);
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("%-10s done, %0d errors", name, test_errors);
		errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		i_request = 1'b0;
		i_req = '0;
		seed = 75;
		checks = 0;
		errors = 0;
		test_errors = 0;
		for (n = 0; n < (1 << `RAM_ADDR_BITS); n++)
			model[n] = '0;

		n = 0;
		while (i_rst !== 1'b0 && n < 50) begin
			@(negedge i_clock);
			n++;
		end
		assert (i_rst === 1'b0) else begin
			$display("Timeout at %0d ns, reset was never released", $time);
			test_errors++;
		end
		check(o_empty === 1'b1 && o_full === 1'b0 && o_ready === 1'b0,
			$sformatf("after reset empty=%b full=%b ready=%b", o_empty, o_full, o_ready));
		end_test("reset");

		for (n = 0; n < 10; n++) begin
			rnd = $random(seed);
			addrs[n] = {rnd[31:2], 2'b00};
			access(1'b1, addrs[n], $random(seed));
		end
		for (n = 0; n < 10; n++)
			read_check(addrs[n]);
		end_test("write_read");

		// Back to back writes keep the FSM busy and nothing drains
		wait_idle();
		for (n = 0; n <= `WBUF_DEPTH; n++) begin
			rnd = $random(seed);
			addrs[n] = {rnd[31:2], 2'b00};
			access(1'b1, addrs[n], $random(seed));
			check(o_empty === 1'b0, $sformatf("queue empty after write %0d", n));
			if (n < `WBUF_DEPTH)
				check(cycles == 1, $sformatf("write %0d took %0d cycles", n, cycles));
			if (n == `WBUF_DEPTH - 1)
				check(o_full === 1'b1, "queue not full after eight writes");
		end
		check(full_low && cycles > 1, "ninth write acknowledged while the queue was full");
		end_test("fill");

		wait_idle();
		for (n = 0; n <= `WBUF_DEPTH; n++)
			read_check(addrs[n]);
		end_test("drain");

		for (n = 0; n < 300; n++) begin
			rnd = $random(seed);
			// Word index 0 to 15 with random upper address bits
			addr = {rnd[31:10], 4'b0000, rnd[3:0], 2'b00};
			if (rnd[4])
				access(1'b1, addr, $random(seed));
			else
				read_check(addr);
			repeat (rnd[6:5]) @(negedge i_clock);
		end
		end_test("mix");

		wait_idle();
		check(o_empty === 1'b1 && o_full === 1'b0, "queue not idle after the random mix");
		end_test("idle");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
hw/wbuf_pkg.sv
hw/write_queue.sv
hw/write_buffer.sv
hw/bus_ram.sv
hw/buffered_memory.sv
bench/clock_gen.sv
bench/buffered_memory_props.sv
bench/buffered_memory_tb.sv

// ==== Makefile ====
# Verilator build and run for the buffered memory testbench

VERILATOR ?= verilator
TOP ?= buffered_memory_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= test passed
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
